// File: design/dispatchPkg.sv
`default_nettype none

package dispatchPkg;

  // Stage sizes
  localparam int DispatchWidth  = 4;    // Lanes per bundle
  localparam int Checkpoints    = 8;    // Outstanding branch checkpoints
  localparam int CheckpointsLog = 3;
  localparam int SizeLsq        = 16;   // Load queue and store queue, each
  localparam int SizeIssueQ     = 32;
  localparam int SizeActiveList = 64;

  // Instruction fields
  typedef logic [31:0] pcT;
  typedef logic [7:0]  opcodeT;
  typedef logic [4:0]  logRegT;           // Architectural register
  typedef logic [6:0]  physRegT;          // Physical register tag

  // Branch tracking
  typedef logic [Checkpoints-1:0]    branchMaskT;
  typedef logic [CheckpointsLog-1:0] checkpointIdT;

  // Occupancy counts carry one extra bit so that a full queue fits
  typedef logic [$clog2(SizeLsq):0]        lsqCntT;
  typedef logic [$clog2(SizeIssueQ):0]     iqCntT;
  typedef logic [$clog2(SizeActiveList):0] alCntT;

  // Number of lanes in a bundle, 0 to DispatchWidth
  typedef logic [$clog2(DispatchWidth):0]  laneCntT;

endpackage

`default_nettype wire

// File: design/renameLatch.sv
`timescale 1ns/1ps
`default_nettype none

module renameLatch (
  input  wire                          clk,
  input  wire                          rstN_i,
  input  wire                          renameReady_i,     // Rename has a bundle
  input  wire                          flagRecoverEX_i,
  input  wire                          dispatch_i,        // Back end takes the bundle
  input  wire                          ctrlVerified_i,
  input  wire dispatchPkg::checkpointIdT ctrlVerifiedId_i,

  input  wire dispatchPkg::pcT         pc_i         [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::opcodeT     opcode_i     [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::logRegT     destLog_i    [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    destPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    prevPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    srcAPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    srcBPhys_i   [dispatchPkg::DispatchWidth],
  input  wire                          isLoad_i     [dispatchPkg::DispatchWidth],
  input  wire                          isStore_i    [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::branchMaskT branchMask_i [dispatchPkg::DispatchWidth],
  input  wire                          laneValid_i  [dispatchPkg::DispatchWidth],

  output logic                         bundleValid_o,
  output dispatchPkg::pcT              pc_o         [dispatchPkg::DispatchWidth],
  output dispatchPkg::opcodeT          opcode_o     [dispatchPkg::DispatchWidth],
  output dispatchPkg::logRegT          destLog_o    [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         destPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         prevPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         srcAPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         srcBPhys_o   [dispatchPkg::DispatchWidth],
  output logic                         isLoad_o     [dispatchPkg::DispatchWidth],
  output logic                         isStore_o    [dispatchPkg::DispatchWidth],
  output dispatchPkg::branchMaskT      branchMask_o [dispatchPkg::DispatchWidth],
  output logic                         laneValid_o  [dispatchPkg::DispatchWidth]
);

  logic                    bundleValidQ;
  logic                    captureEn;
  dispatchPkg::branchMaskT maskQ [dispatchPkg::DispatchWidth];

  // Drop the checkpoint of a branch that resolved correctly
  function automatic dispatchPkg::branchMaskT clearVerified(
    input dispatchPkg::branchMaskT   mask,
    input logic                      verified,
    input dispatchPkg::checkpointIdT id
  );
    dispatchPkg::branchMaskT result;
    result = mask;
    if (verified)
      result[id] = 1'b0;
    return result;
  endfunction

  // New bundle only into an empty slot or one that leaves this cycle
  assign captureEn = renameReady_i & ~flagRecoverEX_i & (~bundleValidQ | dispatch_i);

  always_ff @(posedge clk or negedge rstN_i)
  begin
    if (!rstN_i)
      bundleValidQ <= 1'b0;
    else if (flagRecoverEX_i)
      bundleValidQ <= 1'b0;            // Squash whatever is held
    else if (captureEn)
      bundleValidQ <= 1'b1;
    else if (dispatch_i)
      bundleValidQ <= 1'b0;
  end

  // Bundle payload
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < dispatchPkg::DispatchWidth; i++)
    begin
      if (captureEn)
      begin
        pc_o[i]       <= pc_i[i];
        opcode_o[i]   <= opcode_i[i];
        destLog_o[i]  <= destLog_i[i];
        destPhys_o[i] <= destPhys_i[i];
        prevPhys_o[i] <= prevPhys_i[i];
        srcAPhys_o[i] <= srcAPhys_i[i];
        srcBPhys_o[i] <= srcBPhys_i[i];
        isLoad_o[i]   <= isLoad_i[i];
        isStore_o[i]  <= isStore_i[i];
        laneValid_o[i] <= laneValid_i[i];
        maskQ[i]      <= clearVerified(branchMask_i[i], ctrlVerified_i, ctrlVerifiedId_i);
      end
      else
      begin
        // Held bundle keeps only its mask updates
        maskQ[i] <= clearVerified(maskQ[i], ctrlVerified_i, ctrlVerifiedId_i);
      end
    end
  end

  // Masks leave with this cycle's resolution already applied
  always_comb
  begin
    for (int i = 0; i < dispatchPkg::DispatchWidth; i++)
      branchMask_o[i] = clearVerified(maskQ[i], ctrlVerified_i, ctrlVerifiedId_i);
  end

  assign bundleValid_o = bundleValidQ;

  // A recovery leaves nothing behind in the latch
  recoverEmpties: assert property (
    @(posedge clk) disable iff (!rstN_i)
    flagRecoverEX_i |=> !bundleValid_o
  ) else $error("Bundle still valid after recovery");

endmodule

`default_nettype wire

// File: design/dispatchControl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchControl (
  input  wire                     bundleValid_i,
  input  wire                     flagRecoverEX_i,
  input  wire                     laneValid_i [dispatchPkg::DispatchWidth],
  input  wire                     isLoad_i    [dispatchPkg::DispatchWidth],
  input  wire                     isStore_i   [dispatchPkg::DispatchWidth],

  input  wire dispatchPkg::lsqCntT loadQueueCnt_i,   // Entries in use, load queue
  input  wire dispatchPkg::lsqCntT storeQueueCnt_i,  // Entries in use, store queue
  input  wire dispatchPkg::iqCntT  issueQueueCnt_i,
  input  wire dispatchPkg::alCntT  activeListCnt_i,

  output logic                    dispatch_o,
  output logic                    stallFrontEnd_o,
  output logic                    issueValid_o [dispatchPkg::DispatchWidth],
  output logic                    alValid_o    [dispatchPkg::DispatchWidth],
  output logic                    lsqValid_o   [dispatchPkg::DispatchWidth]
);

  // Per-lane demand, valid lanes only
  logic [dispatchPkg::DispatchWidth-1:0] loadVec;
  logic [dispatchPkg::DispatchWidth-1:0] storeVec;
  logic [dispatchPkg::DispatchWidth-1:0] liveVec;

  dispatchPkg::laneCntT loadCnt;
  dispatchPkg::laneCntT storeCnt;
  dispatchPkg::laneCntT laneCnt;

  // One bit wider than the occupancy so the sum cannot wrap
  logic [$bits(dispatchPkg::lsqCntT):0] loadSum;
  logic [$bits(dispatchPkg::lsqCntT):0] storeSum;
  logic [$bits(dispatchPkg::iqCntT):0]  issueSum;
  logic [$bits(dispatchPkg::alCntT):0]  alSum;

  logic loadFull;
  logic storeFull;
  logic issueFull;
  logic alFull;
  logic room;

  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    laneCnt  = '0;
    for (int i = 0; i < dispatchPkg::DispatchWidth; i++)
    begin
      loadVec[i]  = laneValid_i[i] & isLoad_i[i];
      storeVec[i] = laneValid_i[i] & isStore_i[i];
      liveVec[i]  = laneValid_i[i];
      loadCnt     = loadCnt + dispatchPkg::laneCntT'(loadVec[i]);
      storeCnt    = storeCnt + dispatchPkg::laneCntT'(storeVec[i]);
      laneCnt     = laneCnt + dispatchPkg::laneCntT'(liveVec[i]);
    end
  end

  assign loadSum  = {1'b0, loadQueueCnt_i} + {3'b000, loadCnt};
  assign storeSum = {1'b0, storeQueueCnt_i} + {3'b000, storeCnt};
  assign issueSum = {1'b0, issueQueueCnt_i} + {4'b0000, laneCnt};
  assign alSum    = {1'b0, activeListCnt_i} + {5'b00000, laneCnt};

  // Space checks, whole bundle or nothing
  assign loadFull  = loadSum > dispatchPkg::SizeLsq;
  assign storeFull = storeSum > dispatchPkg::SizeLsq;
  assign issueFull = issueSum > dispatchPkg::SizeIssueQ;
  assign alFull    = alSum > dispatchPkg::SizeActiveList;
  assign room      = ~(loadFull | storeFull | issueFull | alFull);

  assign dispatch_o      = bundleValid_i & room & ~flagRecoverEX_i;
  assign stallFrontEnd_o = bundleValid_i & ~room;   // Rename holds its bundle

  always_comb
  begin
    for (int i = 0; i < dispatchPkg::DispatchWidth; i++)
    begin
      issueValid_o[i] = dispatch_o & liveVec[i];
      alValid_o[i]    = dispatch_o & liveVec[i];
      lsqValid_o[i]   = dispatch_o & (loadVec[i] | storeVec[i]);  // Memory ops only
    end
  end

  // Counted independently of the adders above
  always_comb
  begin
    if (dispatch_o)
    begin
      assert (
        (int'(loadQueueCnt_i) + $countones(loadVec) <= dispatchPkg::SizeLsq) &&
        (int'(storeQueueCnt_i) + $countones(storeVec) <= dispatchPkg::SizeLsq) &&
        (int'(issueQueueCnt_i) + $countones(liveVec) <= dispatchPkg::SizeIssueQ) &&
        (int'(activeListCnt_i) + $countones(liveVec) <= dispatchPkg::SizeActiveList)
      ) else $error("Dispatch without room in the back end");
    end
  end

endmodule

`default_nettype wire

// File: design/Dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module Dispatch (
  input  wire                          clk,
  input  wire                          rstN_i,
  input  wire                          renameReady_i,
  input  wire                          flagRecoverEX_i,
  input  wire                          ctrlVerified_i,     // Branch resolved correctly
  input  wire dispatchPkg::checkpointIdT ctrlVerifiedId_i,

  // Renamed bundle from rename
  input  wire dispatchPkg::pcT         pc_i         [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::opcodeT     opcode_i     [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::logRegT     destLog_i    [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    destPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    prevPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    srcAPhys_i   [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::physRegT    srcBPhys_i   [dispatchPkg::DispatchWidth],
  input  wire                          isLoad_i     [dispatchPkg::DispatchWidth],
  input  wire                          isStore_i    [dispatchPkg::DispatchWidth],
  input  wire dispatchPkg::branchMaskT branchMask_i [dispatchPkg::DispatchWidth],
  input  wire                          laneValid_i  [dispatchPkg::DispatchWidth],

  // Back-end occupancy
  input  wire dispatchPkg::lsqCntT     loadQueueCnt_i,
  input  wire dispatchPkg::lsqCntT     storeQueueCnt_i,
  input  wire dispatchPkg::iqCntT      issueQueueCnt_i,
  input  wire dispatchPkg::alCntT      activeListCnt_i,

  // Dispatched bundle
  output dispatchPkg::pcT              pc_o         [dispatchPkg::DispatchWidth],
  output dispatchPkg::opcodeT          opcode_o     [dispatchPkg::DispatchWidth],
  output dispatchPkg::logRegT          destLog_o    [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         destPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         prevPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         srcAPhys_o   [dispatchPkg::DispatchWidth],
  output dispatchPkg::physRegT         srcBPhys_o   [dispatchPkg::DispatchWidth],
  output logic                         isLoad_o     [dispatchPkg::DispatchWidth],
  output logic                         isStore_o    [dispatchPkg::DispatchWidth],
  output dispatchPkg::branchMaskT      branchMask_o [dispatchPkg::DispatchWidth],
  output logic                         laneValid_o  [dispatchPkg::DispatchWidth],

  // Per-lane write strobes
  output logic                         issueValid_o [dispatchPkg::DispatchWidth],
  output logic                         alValid_o    [dispatchPkg::DispatchWidth],
  output logic                         lsqValid_o   [dispatchPkg::DispatchWidth],

  output logic                         bundleValid_o,
  output logic                         dispatchValid_o,
  output logic                         stallFrontEnd_o
);

  logic bundleValid;
  logic dispatch;

  renameLatch renameLatch_inst (
    .clk              (clk),
    .rstN_i           (rstN_i),
    .renameReady_i    (renameReady_i),
    .flagRecoverEX_i  (flagRecoverEX_i),
    .dispatch_i       (dispatch),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlVerifiedId_i (ctrlVerifiedId_i),
    .pc_i             (pc_i),
    .opcode_i         (opcode_i),
    .destLog_i        (destLog_i),
    .destPhys_i       (destPhys_i),
    .prevPhys_i       (prevPhys_i),
    .srcAPhys_i       (srcAPhys_i),
    .srcBPhys_i       (srcBPhys_i),
    .isLoad_i         (isLoad_i),
    .isStore_i        (isStore_i),
    .branchMask_i     (branchMask_i),
    .laneValid_i      (laneValid_i),
    .bundleValid_o    (bundleValid),
    .pc_o             (pc_o),
    .opcode_o         (opcode_o),
    .destLog_o        (destLog_o),
    .destPhys_o       (destPhys_o),
    .prevPhys_o       (prevPhys_o),
    .srcAPhys_o       (srcAPhys_o),
    .srcBPhys_o       (srcBPhys_o),
    .isLoad_o         (isLoad_o),
    .isStore_o        (isStore_o),
    .branchMask_o     (branchMask_o),
    .laneValid_o      (laneValid_o)
  );

  // Decides on the held bundle, not on what rename offers
  dispatchControl dispatchControl_inst (
    .bundleValid_i    (bundleValid),
    .flagRecoverEX_i  (flagRecoverEX_i),
    .laneValid_i      (laneValid_o),
    .isLoad_i         (isLoad_o),
    .isStore_i        (isStore_o),
    .loadQueueCnt_i   (loadQueueCnt_i),
    .storeQueueCnt_i  (storeQueueCnt_i),
    .issueQueueCnt_i  (issueQueueCnt_i),
    .activeListCnt_i  (activeListCnt_i),
    .dispatch_o       (dispatch),
    .stallFrontEnd_o  (stallFrontEnd_o),
    .issueValid_o     (issueValid_o),
    .alValid_o        (alValid_o),
    .lsqValid_o       (lsqValid_o)
  );

  assign bundleValid_o   = bundleValid;
  assign dispatchValid_o = dispatch;

endmodule

`default_nettype wire

// File: dv/dispatchVectors.svh
  // Columns, first line: name, load/store/issue/active list occupancy, lane valid, load, store
  // Second line: lane masks (byte i is lane i), verify, verify id, recover, expected stall,
  // then lsqValid, issueValid and masks expected when the bundle leaves
  task automatic loadVectors();
    addRow("room_full_bundle",    0,  0,  0,  0, 4'b1111, 4'b0011, 4'b1100,
           32'h0f0f_0f0f, 0, 0, 0,   0, 4'b1111, 4'b1111, 32'h0f0f_0f0f);
    addRow("partial_bundle",      0,  0,  0,  0, 4'b0101, 4'b1001, 4'b0110,
           32'h0000_0301, 0, 0, 0,   0, 4'b0101, 4'b0101, 32'h0000_0301);
    addRow("lsq_upper_lanes",     0,  0,  0,  0, 4'b1111, 4'b0100, 4'b1000,
           32'h8040_2010, 0, 0, 0,   0, 4'b1100, 4'b1111, 32'h8040_2010);
    addRow("no_memory_ops",       0,  0,  0,  0, 4'b1111, 4'b0000, 4'b0000,
           32'h0000_0000, 0, 0, 0,   0, 4'b0000, 4'b1111, 32'h0000_0000);
    addRow("load_queue_edge",    14,  0,  0,  0, 4'b1111, 4'b0011, 4'b0000,
           32'h0101_0101, 0, 0, 0,   0, 4'b0011, 4'b1111, 32'h0101_0101);
    addRow("load_queue_full",    15,  0,  0,  0, 4'b1111, 4'b0011, 4'b0000,
           32'h0202_0202, 0, 0, 0,   1, 4'b0011, 4'b1111, 32'h0202_0202);
    addRow("store_queue_full",    0, 14,  0,  0, 4'b1111, 4'b0000, 4'b1110,
           32'h0303_0303, 0, 0, 0,   1, 4'b1110, 4'b1111, 32'h0303_0303);
    addRow("issue_queue_edge",    0,  0, 28, 60, 4'b1111, 4'b0000, 4'b0000,
           32'h1020_4080, 0, 0, 0,   0, 4'b0000, 4'b1111, 32'h1020_4080);
    addRow("issue_queue_full",    0,  0, 29,  0, 4'b1111, 4'b0000, 4'b0000,
           32'h0808_0808, 0, 0, 0,   1, 4'b0000, 4'b1111, 32'h0808_0808);
    addRow("active_list_full",    0,  0,  0, 62, 4'b0111, 4'b0000, 4'b0000,
           32'h0000_0000, 0, 0, 0,   1, 4'b0000, 4'b0111, 32'h0000_0000);
    addRow("mask_clear",          0,  0,  0,  0, 4'b1111, 4'b0001, 4'b0010,
           32'hffff_ffff, 1, 5, 0,   0, 4'b0011, 4'b1111, 32'hdfdf_dfdf);
    addRow("mask_clear_stall",    0,  0,  0, 64, 4'b1111, 4'b0000, 4'b0000,
           32'h2c24_0604, 1, 2, 0,   1, 4'b0000, 4'b1111, 32'h2820_0200);
    addRow("recover_flush",       0,  0,  0,  0, 4'b1111, 4'b0011, 4'b0000,
           32'h0404_0404, 0, 0, 1,   0, 4'b0000, 4'b0000, 32'h0404_0404);
    addRow("recover_when_full",  16,  0,  0,  0, 4'b1111, 4'b0001, 4'b0000,
           32'h1111_1111, 0, 0, 1,   1, 4'b0000, 4'b0000, 32'h1111_1111);
  endtask

// File: dv/DispatchTb.sv
`timescale 1ns/1ps
`default_nettype none

module DispatchTb;

  localparam int Lanes  = dispatchPkg::DispatchWidth;
  localparam int Period = 10;

  // Bit i of a lane vector and byte i of a mask word belong to lane i
  typedef struct packed {
    dispatchPkg::lsqCntT       ldCnt;
    dispatchPkg::lsqCntT       stCnt;
    dispatchPkg::iqCntT        iqCnt;
    dispatchPkg::alCntT        alCnt;
    logic [3:0]                valid;
    logic [3:0]                load;
    logic [3:0]                store;
    logic [31:0]               mask;
    logic                      verify;
    dispatchPkg::checkpointIdT verifyId;
    logic                      recover;
    logic                      expStall;
    logic [3:0]                expLsq;
    logic [3:0]                expIssue;
    logic [31:0]               expMask;
  } vecRowT;

  logic                      clk;
  logic                      rstN_i;
  logic                      renameReady_i;
  logic                      flagRecoverEX_i;
  logic                      ctrlVerified_i;
  dispatchPkg::checkpointIdT ctrlVerifiedId_i;
  dispatchPkg::lsqCntT       loadQueueCnt_i;
  dispatchPkg::lsqCntT       storeQueueCnt_i;
  dispatchPkg::iqCntT        issueQueueCnt_i;
  dispatchPkg::alCntT        activeListCnt_i;
  dispatchPkg::pcT           pc_i         [Lanes];
  dispatchPkg::opcodeT       opcode_i     [Lanes];
  dispatchPkg::logRegT       destLog_i    [Lanes];
  dispatchPkg::physRegT      destPhys_i   [Lanes];
  dispatchPkg::physRegT      prevPhys_i   [Lanes];
  dispatchPkg::physRegT      srcAPhys_i   [Lanes];
  dispatchPkg::physRegT      srcBPhys_i   [Lanes];
  logic                      isLoad_i     [Lanes];
  logic                      isStore_i    [Lanes];
  dispatchPkg::branchMaskT   branchMask_i [Lanes];
  logic                      laneValid_i  [Lanes];
  dispatchPkg::pcT           pc_o         [Lanes];
  dispatchPkg::opcodeT       opcode_o     [Lanes];
  dispatchPkg::logRegT       destLog_o    [Lanes];
  dispatchPkg::physRegT      destPhys_o   [Lanes];
  dispatchPkg::physRegT      prevPhys_o   [Lanes];
  dispatchPkg::physRegT      srcAPhys_o   [Lanes];
  dispatchPkg::physRegT      srcBPhys_o   [Lanes];
  logic                      isLoad_o     [Lanes];
  logic                      isStore_o    [Lanes];
  dispatchPkg::branchMaskT   branchMask_o [Lanes];
  logic                      laneValid_o  [Lanes];
  logic                      issueValid_o [Lanes];
  logic                      alValid_o    [Lanes];
  logic                      lsqValid_o   [Lanes];
  logic                      bundleValid_o;
  logic                      dispatchValid_o;
  logic                      stallFrontEnd_o;

  string       rowName [$];
  vecRowT      rowData [$];
  logic [31:0] lcgState = 32'h749b_4656;
  logic [31:0] sentPc   [Lanes];   // Fields as captured, before rename moves on
  logic [63:0] sentRegs [Lanes];
  string       testName;
  int          testErrors;
  int          failedTests;

  Dispatch Dispatch_inst (.*);

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [3:0] packBits(input logic bits [Lanes]);
    logic [3:0] v;
    for (int i = 0; i < Lanes; i++)
      v[i] = bits[i];
    return v;
  endfunction

  function automatic logic [31:0] packMasks();
    logic [31:0] v;
    for (int i = 0; i < Lanes; i++)
      v[8*i +: 8] = branchMask_o[i];
    return v;
  endfunction

  task automatic addRow(
    input string                     name,
    input dispatchPkg::lsqCntT       ld, st,
    input dispatchPkg::iqCntT        iq,
    input dispatchPkg::alCntT        al,
    input logic [3:0]                valid, load, store,
    input logic [31:0]               mask,
    input logic                      verify,
    input dispatchPkg::checkpointIdT vid,
    input logic                      recover, expStall,
    input logic [3:0]                expLsq, expIssue,
    input logic [31:0]               expMask
  );
    rowName.push_back(name);
    rowData.push_back({ld, st, iq, al, valid, load, store, mask, verify, vid, recover,
                       expStall, expLsq, expIssue, expMask});
  endtask

  `include "dispatchVectors.svh"

  task automatic compareValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("Fail %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportError(input string msg);
    $display("Error in %s: %s", testName, msg);
    testErrors++;
  endtask

  task automatic finishTest();
    if (testErrors == 0)
      $display("Test %s: ok", testName);
    else
    begin
      $display("Test %s: %0d mismatches", testName, testErrors);
      failedTests++;
    end
  endtask

  task automatic randomizeFields();
    logic [31:0] r;
    for (int i = 0; i < Lanes; i++)
    begin
      pc_i[i]       = lcgNext();
      r             = lcgNext();
      opcode_i[i]   = r[7:0];
      destLog_i[i]  = r[12:8];
      destPhys_i[i] = r[19:13];
      prevPhys_i[i] = r[26:20];
      r             = lcgNext();
      srcAPhys_i[i] = r[6:0];
      srcBPhys_i[i] = r[13:7];
    end
  endtask

  task automatic driveBundle(input vecRowT row);
    randomizeFields();
    for (int i = 0; i < Lanes; i++)
    begin
      sentPc[i]       = pc_i[i];
      sentRegs[i]     = {opcode_i[i], destLog_i[i], destPhys_i[i], prevPhys_i[i],
                         srcAPhys_i[i], srcBPhys_i[i]};
      isLoad_i[i]     = row.load[i];
      isStore_i[i]    = row.store[i];
      laneValid_i[i]  = row.valid[i];
      branchMask_i[i] = row.mask[8*i +: 8];
    end
    loadQueueCnt_i  = row.ldCnt;
    storeQueueCnt_i = row.stCnt;
    issueQueueCnt_i = row.iqCnt;
    activeListCnt_i = row.alCnt;
    renameReady_i   = 1'b1;
  endtask

  task automatic checkFields(input vecRowT row);
    for (int i = 0; i < Lanes; i++)
    begin
      compareValue($sformatf("pc lane %0d", i), sentPc[i], pc_o[i]);
      compareValue($sformatf("regs lane %0d", i), sentRegs[i],
                   {opcode_o[i], destLog_o[i], destPhys_o[i], prevPhys_o[i],
                    srcAPhys_o[i], srcBPhys_o[i]});
    end
    compareValue("laneValid", row.valid, packBits(laneValid_o));
    compareValue("isLoad", row.load, packBits(isLoad_o));
    compareValue("isStore", row.store, packBits(isStore_o));
  endtask

  task automatic checkStrobes(input logic [3:0] lsq, input logic [3:0] issue);
    compareValue("issueValid", issue, packBits(issueValid_o));
    compareValue("alValid", issue, packBits(alValid_o));
    compareValue("lsqValid", lsq, packBits(lsqValid_o));
  endtask

  task automatic runRow(input int idx);
    vecRowT row;
    logic   leaves;
    int     waited;
    row        = rowData[idx];
    testName   = rowName[idx];
    testErrors = 0;
    leaves     = !row.expStall && !row.recover;
    @(negedge clk);
    driveBundle(row);
    @(negedge clk);                   // Captured at the rising edge in between
    // Rename offers its next bundle, which a stalled or flushed latch must refuse
    renameReady_i    = row.expStall || row.recover;
    flagRecoverEX_i  = row.recover;
    ctrlVerified_i   = row.verify;
    ctrlVerifiedId_i = row.verifyId;
    randomizeFields();                // The latch must not follow rename
    #2;
    compareValue("bundleValid", 1, bundleValid_o);
    compareValue("stallFrontEnd", row.expStall, stallFrontEnd_o);
    compareValue("dispatchValid", leaves, dispatchValid_o);
    compareValue("branchMask", row.expMask, packMasks());
    if (leaves)
    begin
      checkFields(row);
      checkStrobes(row.expLsq, row.expIssue);
    end
    else
      checkStrobes(4'b0000, 4'b0000);
    @(negedge clk);
    renameReady_i   = row.expStall && !row.recover;
    flagRecoverEX_i = 1'b0;
    ctrlVerified_i  = 1'b0;
    if (row.expStall && !row.recover)
    begin
      #2;
      // Cleared bit now comes from the stored copy
      compareValue("stallFrontEnd held", 1, stallFrontEnd_o);
      compareValue("branchMask held", row.expMask, packMasks());
      @(negedge clk);
      renameReady_i   = 1'b0;
      loadQueueCnt_i  = '0;
      storeQueueCnt_i = '0;
      issueQueueCnt_i = '0;
      activeListCnt_i = '0;
      #2;
      waited = 0;
      while (dispatchValid_o !== 1'b1 && waited < 4)
      begin
        @(negedge clk);
        #2;
        waited++;
      end
      if (dispatchValid_o !== 1'b1)
        reportError("bundle never dispatched after the back end drained");
      else
      begin
        compareValue("stallFrontEnd drained", 0, stallFrontEnd_o);
        compareValue("branchMask drained", row.expMask, packMasks());
        checkFields(row);
        checkStrobes(row.expLsq, row.expIssue);
      end
      @(negedge clk);
    end
    #2;
    compareValue("bundleValid after", 0, bundleValid_o);
    compareValue("dispatchValid after", 0, dispatchValid_o);
    finishTest();
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  initial
  begin
    failedTests      = 0;
    rstN_i           = 1'b0;
    renameReady_i    = 1'b0;
    flagRecoverEX_i  = 1'b0;
    ctrlVerified_i   = 1'b0;
    ctrlVerifiedId_i = '0;
    loadQueueCnt_i   = '0;
    storeQueueCnt_i  = '0;
    issueQueueCnt_i  = '0;
    activeListCnt_i  = '0;
    for (int i = 0; i < Lanes; i++)
    begin
      pc_i[i]         = '0;
      opcode_i[i]     = '0;
      destLog_i[i]    = '0;
      destPhys_i[i]   = '0;
      prevPhys_i[i]   = '0;
      srcAPhys_i[i]   = '0;
      srcBPhys_i[i]   = '0;
      isLoad_i[i]     = 1'b0;
      isStore_i[i]    = 1'b0;
      branchMask_i[i] = '0;
      laneValid_i[i]  = 1'b0;
    end
    loadVectors();
    repeat (2) @(negedge clk);
    rstN_i = 1'b1;
    #2;
    testName   = "reset_state";
    testErrors = 0;
    compareValue("bundleValid", 0, bundleValid_o);
    compareValue("dispatchValid", 0, dispatchValid_o);
    compareValue("stallFrontEnd", 0, stallFrontEnd_o);
    checkStrobes(4'b0000, 4'b0000);
    finishTest();
    for (int i = 0; i < rowData.size(); i++)
      runRow(i);
    $display("Tests run: %0d, tests with mismatches: %0d", rowData.size() + 1, failedTests);
    if (failedTests == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  // Each row needs well under 20 cycles
  initial
  begin
    #1;
    repeat (rowData.size() * 20) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: Dispatch.f
+incdir+dv
design/dispatchPkg.sv
design/renameLatch.sv
design/dispatchControl.sv
design/Dispatch.sv
dv/DispatchTb.sv

// File: Makefile
TOP := DispatchTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f Dispatch.f -o Vsim

# Pass only if the pass message shows up in the simulation output
run: compile
	@out="$$(./obj_dir/Vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
